//--- sim.f
rtl/elink_rx_pkg.sv
rtl/rx_ctrl.sv
rtl/rx_frame_path.sv
rtl/rx_gpio_port.sv
rtl/elink_rx.sv
dv/elink_rx_tb.sv

//--- dv/elink_rx_tb.sv
// eLink receive testbench drives random words through every mode against a reference model
`timescale 1ns/100ps
`default_nettype none

module elink_rx_tb
   import elink_rx_pkg::*;
;

   //####################
   // Run lengths
   //####################

   localparam int CLK_PERIOD   = 10;        // ns
   localparam int RESET_CYCLES = 5;
   localparam int SETTLE       = 8;         // Quiet cycles after a mode change
   localparam int MODE_CHANGES = 7;
   localparam int RUN_ENABLED  = 200;
   localparam int RUN_SHORT    = 50;
   localparam int RUN_TAIL     = 30;
   localparam int TOTAL_CYCLES = RESET_CYCLES + MODE_CHANGES * SETTLE + RUN_ENABLED
                                 + 4 * RUN_SHORT + 2 * RUN_TAIL + 1;

   logic       rxlclk_p;
   logic       rxreset;
   rx_word_t   des_word;
   rx_word_t   loop_word;
   logic       ecfg_rx_enable;
   logic       ecfg_rx_loopback_mode;
   logic       ecfg_rx_gpio_mode;
   gpio_word_t ecfg_dataout;
   gpio_word_t ecfg_datain;
   logic       rx_wr_wait;
   logic       rx_rd_wait;
   logic       tx_wr_wait;
   logic       tx_rd_wait;
   logic       wr_wait_pin;
   logic       rd_wait_pin;
   rx_word_t   rx_word;

   // Mode levels as applied and the compare enable
   logic       mode_en  = 1'b0;
   logic       mode_lb  = 1'b0;
   logic       mode_gp  = 1'b0;
   logic       checking = 1'b1;
   logic [31:0] rng     = 32'hb4b7c0c5;     // xorshift state

   // Input history seen by the compare process is zero while reset holds the DUT
   rx_word_t   des_d1  = '0;
   rx_word_t   des_d2  = '0;
   rx_word_t   loop_d1 = '0;
   rx_word_t   exp_d1  = '0;                // Expected rx_word one and two cycles back
   rx_word_t   exp_d2  = '0;
   logic [1:0] txw_d   = '0;                // Transmitter write wait with [0] newest
   logic [1:0] txr_d   = '0;
   logic [1:0] chk_d   = 2'b11;             // Compare enable history

   elink_rx #(
      .SYNC_STAGES           (2)
   ) UUT (
      .rxlclk_p              (rxlclk_p),
      .rxreset               (rxreset),
      .des_word              (des_word),
      .loop_word             (loop_word),
      .ecfg_rx_enable        (ecfg_rx_enable),
      .ecfg_rx_loopback_mode (ecfg_rx_loopback_mode),
      .ecfg_rx_gpio_mode     (ecfg_rx_gpio_mode),
      .ecfg_dataout          (ecfg_dataout),
      .ecfg_datain           (ecfg_datain),
      .rx_wr_wait            (rx_wr_wait),
      .rx_rd_wait            (rx_rd_wait),
      .tx_wr_wait            (tx_wr_wait),
      .tx_rd_wait            (tx_rd_wait),
      .wr_wait_pin           (wr_wait_pin),
      .rd_wait_pin           (rd_wait_pin),
      .rx_word               (rx_word)
   );

   //####################
   // Clock and watchdog
   //####################

   initial begin
      rxlclk_p = 1'b0;
      forever #(CLK_PERIOD / 2) rxlclk_p = ~rxlclk_p;
   end

   initial begin
      #(TOTAL_CYCLES * CLK_PERIOD * 2);
      $display("Timeout: the test phases did not finish in the expected time");
      $display(">>> FAIL");
      $fatal(1, "Watchdog expired");
   end

   //####################
   // Helpers
   //####################

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // Frames pass only when enabled and not in GPIO mode
   // The loopback word is one cycle newer
   function automatic rx_word_t expected_rx_word(input rx_word_t des2, input rx_word_t loop1,
                                                 input logic en, input logic lb, input logic gp);
      rx_word_t w;
      if (lb) begin
         w = loop1;
      end else begin
         w.data  = des2.data;
         w.frame = (en && !gp) ? des2.frame : '0;
      end
      return w;
   endfunction

   function automatic gpio_word_t expected_datain(input logic txw, input logic txr,
                                                  input rx_word_t w);
      gpio_word_t d;
      d              = '0;
      d[GPIO_WR_BIT] = txw;
      d[GPIO_RD_BIT] = txr;
      d[8]           = w.frame[0];          // Frame lane 0
      d[7:0]         = w.data[7:0];         // Data byte 0
      return d;
   endfunction

   task automatic check_value(input string name, input logic [71:0] got,
                              input logic [71:0] exp);
      if (got !== exp) begin
         $display("Fail %s: got %h expected %h at %0t", name, got, exp, $time);
         $display(">>> FAIL");
         $fatal(1, "Mismatch on %s", name);
      end
   endtask

   // Fresh random values on every data and wait input
   task automatic drive_random_inputs();
      logic [31:0] r;
      rng = xorshift32(rng);
      des_word.data[31:0]   = rng;
      rng = xorshift32(rng);
      des_word.data[63:32]  = rng;
      rng = xorshift32(rng);
      des_word.frame        = rng[7:0];
      loop_word.frame       = rng[15:8];
      rng = xorshift32(rng);
      loop_word.data[31:0]  = rng;
      rng = xorshift32(rng);
      loop_word.data[63:32] = rng;
      rng = xorshift32(rng);
      r = rng;
      ecfg_dataout = r[10:0];
      rx_wr_wait   = r[11];
      rx_rd_wait   = r[12];
      tx_wr_wait   = r[13];
      tx_rd_wait   = r[14];
   endtask

   task automatic run_cycles(input int n);
      repeat (n) begin
         @(posedge rxlclk_p);
         #1;                                // Drive just after the edge
         drive_random_inputs();
      end
   endtask

   // Compares pause until the synchronizers and FSM have settled
   task automatic set_modes(input logic en, input logic lb, input logic gp);
      checking              = 1'b0;
      mode_en               = en;
      mode_lb               = lb;
      mode_gp               = gp;
      ecfg_rx_enable        = en;
      ecfg_rx_loopback_mode = lb;
      ecfg_rx_gpio_mode     = gp;
      run_cycles(SETTLE);
      checking              = 1'b1;
   endtask

   //####################
   // Compare process
   //####################

   // Falling edge sits between DUT updates and the next drive
   always @(negedge rxlclk_p) begin : compare_outputs
      rx_word_t   exp_word;
      gpio_word_t exp_din;
      logic [1:0] exp_pins;

      exp_word = expected_rx_word(des_d2, loop_d1, mode_en, mode_lb, mode_gp);
      exp_din  = expected_datain(txw_d[1], txr_d[1], exp_d2);
      exp_pins = mode_gp ? {ecfg_dataout[GPIO_WR_BIT], ecfg_dataout[GPIO_RD_BIT]}
                         : {rx_wr_wait, rx_rd_wait};
      if (rxreset) begin
         check_value("rx_word", rx_word, '0);
         check_value("ecfg_datain", ecfg_datain, '0);
      end
      if (checking) begin
         check_value("rx_word", rx_word, exp_word);
         check_value("wr_wait_pin,rd_wait_pin", {wr_wait_pin, rd_wait_pin}, exp_pins);
      end
      if (chk_d[1]) begin
         check_value("ecfg_datain", ecfg_datain, exp_din);
      end
      // Shift history
      des_d2  = des_d1;
      des_d1  = rxreset ? '0 : des_word;
      loop_d1 = rxreset ? '0 : loop_word;
      txw_d   = {txw_d[0], rxreset ? 1'b0 : tx_wr_wait};
      txr_d   = {txr_d[0], rxreset ? 1'b0 : tx_rd_wait};
      exp_d2  = exp_d1;
      exp_d1  = exp_word;
      chk_d   = {chk_d[0], checking};
   end

   //####################
   // Test phases
   //####################

   initial begin
      rxreset               = 1'b1;
      ecfg_rx_enable        = 1'b0;
      ecfg_rx_loopback_mode = 1'b0;
      ecfg_rx_gpio_mode     = 1'b0;
      drive_random_inputs();
      run_cycles(RESET_CYCLES);             // Outputs checked zero throughout
      rxreset = 1'b0;

      set_modes(1'b1, 1'b0, 1'b0);          // Link enabled
      run_cycles(RUN_ENABLED);
      set_modes(1'b0, 1'b0, 1'b0);          // Disabled with frames gated
      run_cycles(RUN_SHORT);
      set_modes(1'b1, 1'b0, 1'b1);          // GPIO owns frames and pins
      run_cycles(RUN_SHORT);
      set_modes(1'b1, 1'b0, 1'b0);          // Back to fabric waits
      run_cycles(RUN_TAIL);
      set_modes(1'b0, 1'b1, 1'b0);          // Loopback with receiver off
      run_cycles(RUN_SHORT);
      set_modes(1'b1, 1'b1, 1'b0);
      run_cycles(RUN_SHORT);
      set_modes(1'b1, 1'b1, 1'b1);          // Loopback frames ignore GPIO gating
      run_cycles(RUN_TAIL);
      @(posedge rxlclk_p);

      $display(">>> PASS");
      $finish;
   end

endmodule

`default_nettype wire

//--- rtl/elink_rx.sv
// eLink receive channel top: joins control, frame path and GPIO port
`timescale 1ns/100ps
`default_nettype none

module elink_rx
   import elink_rx_pkg::*;
#(
   parameter int SYNC_STAGES = 2            // Config synchronizer depth
) (
   input  wire        rxlclk_p,             // Divided receive clock
   input  wire        rxreset,              // Async, active high

   // Line side, already deserialized
   input  rx_word_t   des_word,
   input  rx_word_t   loop_word,            // Transmitter loopback word

   // Configuration, asynchronous levels
   input  wire        ecfg_rx_enable,
   input  wire        ecfg_rx_loopback_mode,
   input  wire        ecfg_rx_gpio_mode,
   input  gpio_word_t ecfg_dataout,         // GPIO override word
   output gpio_word_t ecfg_datain,          // GPIO readback word

   // Wait levels
   input  wire        rx_wr_wait,           // From the fabric
   input  wire        rx_rd_wait,
   input  wire        tx_wr_wait,           // From the transmitter
   input  wire        tx_rd_wait,
   output logic       wr_wait_pin,          // Toward the pads
   output logic       rd_wait_pin,

   // Fabric side
   output rx_word_t   rx_word
);

   //####################
   // Internal levels
   //####################

   logic rx_active;                         // Frames qualified
   logic loopback_on;                       // Loopback word selected
   logic gpio_on;                           // Pins owned by software

   //####################
   // Control
   //####################

   rx_ctrl #(
      .SYNC_STAGES           (SYNC_STAGES)
   ) u_rx_ctrl (
      .rxlclk_p              (rxlclk_p),
      .rxreset               (rxreset),
      .ecfg_rx_enable        (ecfg_rx_enable),
      .ecfg_rx_loopback_mode (ecfg_rx_loopback_mode),
      .ecfg_rx_gpio_mode     (ecfg_rx_gpio_mode),
      .rx_active             (rx_active),
      .loopback_on           (loopback_on),
      .gpio_on               (gpio_on)
   );

   //####################
   // Datapath
   //####################

   rx_frame_path u_rx_frame_path (
      .rxlclk_p    (rxlclk_p),
      .rxreset     (rxreset),
      .des_word    (des_word),
      .loop_word   (loop_word),
      .rx_active   (rx_active),
      .loopback_on (loopback_on),
      .gpio_on     (gpio_on),
      .rx_word     (rx_word)
   );

   // Readback taps the output word, so loopback shows up there too
   rx_gpio_port u_rx_gpio_port (
      .rxlclk_p     (rxlclk_p),
      .rxreset      (rxreset),
      .rx_word      (rx_word),
      .tx_wr_wait   (tx_wr_wait),
      .tx_rd_wait   (tx_rd_wait),
      .ecfg_dataout (ecfg_dataout),
      .rx_wr_wait   (rx_wr_wait),
      .rx_rd_wait   (rx_rd_wait),
      .gpio_on      (gpio_on),
      .ecfg_datain  (ecfg_datain),
      .wr_wait_pin  (wr_wait_pin),
      .rd_wait_pin  (rd_wait_pin)
   );

endmodule

`default_nettype wire

//--- rtl/rx_gpio_port.sv
// Receive GPIO port: captures the readback pin image and selects the wait outputs
`timescale 1ns/100ps
`default_nettype none

module rx_gpio_port
   import elink_rx_pkg::*;
(
   input  wire        rxlclk_p,             // Divided receive clock
   input  wire        rxreset,              // Async, active high
   input  rx_word_t   rx_word,              // Frame 0 and byte 0 used
   input  wire        tx_wr_wait,           // Transmitter wait copies
   input  wire        tx_rd_wait,
   input  gpio_word_t ecfg_dataout,         // Software override word
   input  wire        rx_wr_wait,           // Fabric wait levels
   input  wire        rx_rd_wait,
   input  wire        gpio_on,              // Synced GPIO mode
   output gpio_word_t ecfg_datain,          // Readback to software
   output logic       wr_wait_pin,          // Toward the pads
   output logic       rd_wait_pin
);

   //####################
   // Readback capture
   //####################

   gpio_word_t pin_image;                   // Current pin view
   gpio_word_t datain_reg;                  // First capture stage

   // Waits on top, then frame lane 0, then data byte 0
   assign pin_image = {tx_wr_wait, tx_rd_wait, rx_word.frame[0], rx_word.data[7:0]};

   // Two registers so software reads a settled image
   always_ff @(posedge rxlclk_p or posedge rxreset) begin
      if (rxreset) begin
         datain_reg  <= '0;
         ecfg_datain <= '0;
      end else begin
         datain_reg  <= pin_image;
         ecfg_datain <= datain_reg;
      end
   end

   //####################
   // Wait outputs
   //####################

   // Combinational, so the fabric waits reach the pins without delay
   always_comb begin
      if (gpio_on) begin
         wr_wait_pin = ecfg_dataout[GPIO_WR_BIT]; // Software drives the pins
         rd_wait_pin = ecfg_dataout[GPIO_RD_BIT];
      end else begin
         wr_wait_pin = rx_wr_wait;
         rd_wait_pin = rx_rd_wait;
      end
   end

   //####################
   // Checks
   //####################

   // In GPIO mode the override word owns the write wait pin
   a_gpio_wr_pin : assert property (
      @(posedge rxlclk_p) disable iff (rxreset)
      gpio_on |-> (wr_wait_pin == ecfg_dataout[GPIO_WR_BIT])
   ) else $error("wr_wait_pin not following override bit");

endmodule

`default_nettype wire

//--- rtl/rx_frame_path.sv
// Receive frame path: registers deserialized words, gates frames, muxes in loopback
`timescale 1ns/100ps
`default_nettype none

module rx_frame_path
   import elink_rx_pkg::*;
(
   input  wire      rxlclk_p,               // Divided receive clock
   input  wire      rxreset,                // Async, active high
   input  rx_word_t des_word,               // From the deserializer
   input  rx_word_t loop_word,              // From the transmitter
   input  wire      rx_active,              // Link qualified by rx_ctrl
   input  wire      loopback_on,            // Synced loopback mode
   input  wire      gpio_on,                // Synced GPIO mode
   output rx_word_t rx_word                 // To the fabric
);

   //####################
   // Stage 1
   //####################

   rx_word_t stage_word;                    // Registered deserializer word
   logic     frame_en;                      // Frames allowed this cycle

   // A disabled link or one owned by GPIO never produces frames
   assign frame_en = rx_active & ~gpio_on;

   always_ff @(posedge rxlclk_p or posedge rxreset) begin
      if (rxreset) begin
         stage_word <= '0;
      end else begin
         stage_word.data  <= des_word.data; // Data passes ungated
         stage_word.frame <= des_word.frame & {$bits(rx_frame_t){frame_en}};
      end
   end

   //####################
   // Stage 2
   //####################

   // Loopback words skip stage 1, so they arrive one cycle sooner
   // and keep their frame bits even with the receiver off
   always_ff @(posedge rxlclk_p or posedge rxreset) begin
      if (rxreset) begin
         rx_word <= '0;
      end else if (loopback_on) begin
         rx_word <= loop_word;              // Transmitter word, 1 cycle
      end else begin
         rx_word <= stage_word;             // Line word, 2 cycles
      end
   end

   //####################
   // Checks
   //####################

   // Gating at stage 1 shows up as a clean output one edge later
   a_no_frame_gated : assert property (
      @(posedge rxlclk_p) disable iff (rxreset)
      !frame_en ##1 !loopback_on |=> (rx_word.frame == '0)
   ) else $error("Frame bits leaked while gated: %h", rx_word.frame);

endmodule

`default_nettype wire

//--- rtl/rx_ctrl.sv
// Receive control: syncs config levels into rxlclk_p and sequences off, arm, run
`timescale 1ns/100ps
`default_nettype none

module rx_ctrl
   import elink_rx_pkg::*;
#(
   parameter int SYNC_STAGES = 2            // Synchronizer depth
) (
   input  wire  rxlclk_p,                   // Divided receive clock
   input  wire  rxreset,                    // Async, active high
   input  wire  ecfg_rx_enable,             // Async config level
   input  wire  ecfg_rx_loopback_mode,      // Async config level
   input  wire  ecfg_rx_gpio_mode,          // Async config level
   output logic rx_active,                  // High only in RX_RUN
   output logic loopback_on,                // Synced loopback mode
   output logic gpio_on                     // Synced GPIO mode
);

   // Column index of each config bit inside the sync array
   localparam int CFG_EN = 0;
   localparam int CFG_LB = 1;
   localparam int CFG_GP = 2;

   //####################
   // Synchronizers
   //####################

   // Three chains side by side, stage 0 samples the raw levels
   logic [SYNC_STAGES-1:0][2:0] cfg_sync;
   logic                        en_sync;    // Last enable flop

   // Async clear since rxlclk_p may be stopped while reset is applied
   always_ff @(posedge rxlclk_p or posedge rxreset) begin
      if (rxreset) begin
         cfg_sync <= '0;
      end else begin
         cfg_sync[0] <= {ecfg_rx_gpio_mode, ecfg_rx_loopback_mode, ecfg_rx_enable};
         for (int i = 1; i < SYNC_STAGES; i++) begin
            cfg_sync[i] <= cfg_sync[i-1]; // Shift toward the last stage
         end
      end
   end

   assign en_sync     = cfg_sync[SYNC_STAGES-1][CFG_EN];
   assign loopback_on = cfg_sync[SYNC_STAGES-1][CFG_LB]; // Mode levels leave straight
   assign gpio_on     = cfg_sync[SYNC_STAGES-1][CFG_GP]; // from the last stage

   //####################
   // Control FSM
   //####################

   rx_state_t state;
   rx_state_t state_nxt;

   always_comb begin
      state_nxt = state;                    // Hold by default
      case (state)
         RX_OFF: begin
            if (en_sync) begin
               state_nxt = RX_ARM;          // Enable has settled
            end
         end
         RX_ARM: begin
            state_nxt = en_sync ? RX_RUN : RX_OFF; // One settling cycle
         end
         RX_RUN: begin
            if (!en_sync) begin
               state_nxt = RX_OFF;          // Drop out at once
            end
         end
         default: begin
            state_nxt = RX_OFF;             // Recover from an illegal code
         end
      endcase
   end

   always_ff @(posedge rxlclk_p or posedge rxreset) begin
      if (rxreset) begin
         state <= RX_OFF;
      end else begin
         state <= state_nxt;
      end
   end

   assign rx_active = (state == RX_RUN);    // Frame qualification

   //####################
   // Checks
   //####################

   // Running only after a cycle in which the synced enable was high
   a_active_needs_en : assert property (
      @(posedge rxlclk_p) disable iff (rxreset)
      rx_active |-> $past(en_sync)
   ) else $error("rx_active high without synced enable");

   // State register stays within the three legal codes
   a_state_legal : assert property (
      @(posedge rxlclk_p) disable iff (rxreset)
      state inside {RX_OFF, RX_ARM, RX_RUN}
   ) else $error("Illegal rx_ctrl state %0d", state);

endmodule

`default_nettype wire

//--- rtl/elink_rx_pkg.sv
// eLink receive package: word types, received-word struct and control states
`default_nettype none

package elink_rx_pkg;

   //####################
   // Lane geometry
   //####################

   localparam int RX_LANES  = 8;            // Byte lanes per divided-clock cycle
   localparam int RX_DATA_W = 8 * RX_LANES; // Data bits per divided-clock cycle
   localparam int GPIO_W    = 11;           // GPIO readback / override word width

   // Bit positions of the wait levels inside the GPIO word
   localparam int GPIO_WR_BIT = 10;         // Write wait
   localparam int GPIO_RD_BIT = 9;          // Read wait

   //####################
   // Word types
   //####################

   // Eight bytes received in one rxlclk_p cycle, byte 0 in bits 7..0
   typedef logic [RX_DATA_W-1:0] rx_data_t;

   // One frame bit per byte lane
   typedef logic [RX_LANES-1:0]  rx_frame_t;

   // GPIO word
   //   10   write wait
   //   9    read wait
   //   8    frame lane 0
   //   7..0 data byte 0
   typedef logic [GPIO_W-1:0]    gpio_word_t;

   // Frame and data travel as one 72-bit word
   typedef struct packed {
      rx_frame_t frame; // Upper 8 bits
      rx_data_t  data;  // Lower 64 bits
   } rx_word_t;

   //####################
   // Control states
   //####################

   typedef enum logic [1:0] {
      RX_OFF = 2'd0, // Link disabled, frames suppressed
      RX_ARM = 2'd1, // Enable seen, one settling cycle
      RX_RUN = 2'd2  // Frames qualified
   } rx_state_t;

endpackage

`default_nettype wire
